/* rtl/split_join_macros.svh */
/*
 sizing macros shared by the stream packages and the split/join datapath
 include ahead of any package or module that sizes a stream or the buffer
*/
`ifndef SPLIT_JOIN_MACROS_SVH
`define SPLIT_JOIN_MACROS_SVH

`default_nettype none

// bytes carried by one stream word and so the width of tkeep
`define DATA_BYTE_WID 8

// the payload memory holds 2**8 = 256 words
`define BUF_ADDR_WID 8

// headers are counted in whole words and may span 1 to 15 of them
`define HDR_CNT_WID 4

`default_nettype wire

`endif

/* rtl/axi4s_pkg.sv */
/*
 data types carried on every AXI4-Stream port of the split/join subsystem
 modules take them through a wildcard import in their header
*/
`include "split_join_macros.svh"

`default_nettype none

package axi4s_pkg;

   // ------------------------------
   // stream word types
   // ------------------------------

   // one data word holds eight bits for each byte lane
   typedef logic [`DATA_BYTE_WID*8-1:0] tdata_t;

   // one valid flag for each byte lane of tdata
   typedef logic [`DATA_BYTE_WID-1:0] tkeep_t;

endpackage

`default_nettype wire

/* rtl/buffer_pkg.sv */
/*
 packet buffer addressing and the header context that ties a header to its payload
 the context rides on the header stream tuser and comes back unchanged
*/
`include "split_join_macros.svh"

`default_nettype none

package buffer_pkg;

   // word address inside the payload memory
   typedef logic [`BUF_ADDR_WID-1:0] buf_ptr_t;

   // pld_ptr is the address of the first payload word of the packet
   // pld_present is low when the whole packet fitted inside its header
   typedef struct packed {
      buf_ptr_t pld_ptr;
      logic     pld_present;
   } hdr_ctx_t;

endpackage

`default_nettype wire

/* rtl/axi4s_split.sv */
/*
 header splitter for the in-line header path
 the first hdr_words words of each packet go out on hdr_out with their buffer context
 and every later word is written into the packet buffer on the buf stream
*/
`timescale 1ns/1ps
`include "split_join_macros.svh"

`default_nettype none

module axi4s_split
   import axi4s_pkg::*;
   import buffer_pkg::*;
(
   input  logic                    aclk,
   input  logic                    reset,
   input  tdata_t                  in_tdata,
   input  tkeep_t                  in_tkeep,
   input  logic                    in_tlast,
   input  logic                    in_tvalid,
   output logic                    in_tready,
   output tdata_t                  hdr_out_tdata,
   output tkeep_t                  hdr_out_tkeep,
   output logic                    hdr_out_tlast,
   output logic                    hdr_out_tvalid,
   input  logic                    hdr_out_tready,
   output hdr_ctx_t                hdr_out_tuser,
   output tdata_t                  buf_tdata,
   output tkeep_t                  buf_tkeep,
   output logic                    buf_tlast,
   output logic                    buf_tvalid,
   input  logic                    buf_tready,
   input  buf_ptr_t                buf_wr_ptr,
   input  logic [`HDR_CNT_WID-1:0] hdr_words
);

   typedef enum logic {HDR, PLD} state_t;

   state_t                  state;
   logic [`HDR_CNT_WID-1:0] cnt;
   logic [`HDR_CNT_WID:0]   cnt_next;
   logic [`HDR_CNT_WID-1:0] hdr_lim;
   logic [`HDR_CNT_WID-1:0] lim;
   logic                    hdr_free;
   logic                    buf_free;
   logic                    in_fire;
   logic                    last_hdr;
   logic                    hold_valid;
   tdata_t                  hold_tdata;
   tkeep_t                  hold_tkeep;

   // an output stage can take a word when it is empty or being emptied
   assign hdr_free = !hdr_out_tvalid || hdr_out_tready;
   assign buf_free = !buf_tvalid || buf_tready;
   assign in_fire  = in_tvalid && in_tready;

   // hdr_words is only looked at on the first word of a packet
   assign lim      = (state == HDR && cnt == '0) ? hdr_words : hdr_lim;
   assign cnt_next = {1'b0, cnt} + 1'b1;
   // a zero count behaves like a one word header
   assign last_hdr = in_tlast || (cnt_next >= {1'b0, lim});

   // releasing the held header word loads both output stages at once
   always_comb begin
      if (state == HDR) begin
         in_tready = hdr_free;
      end else if (hold_valid) begin
         in_tready = hdr_free && buf_free;
      end else begin
         in_tready = buf_free;
      end
   end

   // ------------------------------
   // steering and handshake state
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (reset) begin
         state          <= HDR;
         cnt            <= '0;
         hdr_lim        <= '0;
         hold_valid     <= 1'b0;
         hdr_out_tvalid <= 1'b0;
         buf_tvalid     <= 1'b0;
      end else begin
         if (hdr_out_tready) hdr_out_tvalid <= 1'b0;
         if (buf_tready) buf_tvalid <= 1'b0;
         if (in_fire && state == HDR) begin
            if (cnt == '0) hdr_lim <= hdr_words;
            cnt <= last_hdr ? '0 : cnt_next[`HDR_CNT_WID-1:0];
            // the last header word of a longer packet waits for its payload pointer
            if (last_hdr && !in_tlast) begin
               hold_valid <= 1'b1;
               state      <= PLD;
            end else begin
               hdr_out_tvalid <= 1'b1;
            end
         end
         if (in_fire && state == PLD) begin
            buf_tvalid <= 1'b1;
            if (hold_valid) begin
               hold_valid     <= 1'b0;
               hdr_out_tvalid <= 1'b1;
            end
            if (in_tlast) state <= HDR;
         end
      end
   end

   // ------------------------------
   // word registers
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (in_fire && state == HDR) begin
         if (last_hdr && !in_tlast) begin
            hold_tdata <= in_tdata;
            hold_tkeep <= in_tkeep;
         end else begin
            hdr_out_tdata <= in_tdata;
            hdr_out_tkeep <= in_tkeep;
            hdr_out_tlast <= in_tlast;
            // a header that ends the packet carries no payload context
            hdr_out_tuser <= hdr_ctx_t'{pld_ptr: buf_wr_ptr, pld_present: 1'b0};
         end
      end
      if (in_fire && state == PLD) begin
         buf_tdata <= in_tdata;
         buf_tkeep <= in_tkeep;
         buf_tlast <= in_tlast;
         if (hold_valid) begin
            hdr_out_tdata <= hold_tdata;
            hdr_out_tkeep <= hold_tkeep;
            hdr_out_tlast <= 1'b1;
            // a word still leaving buf this cycle lands at buf_wr_ptr, so ours goes one later
            hdr_out_tuser <= hdr_ctx_t'{pld_ptr: buf_wr_ptr + buf_ptr_t'(buf_tvalid),
                                        pld_present: 1'b1};
         end
      end
   end

   // the header processor must see a stalled word unchanged until it takes it
   a_hdr_stable: assert property (@(posedge aclk) disable iff (reset)
      hdr_out_tvalid && !hdr_out_tready |=> hdr_out_tvalid && $stable(hdr_out_tdata)
         && $stable(hdr_out_tkeep) && $stable(hdr_out_tlast) && $stable(hdr_out_tuser));

endmodule

`default_nettype wire

/* rtl/axi4s_pkt_buffer.sv */
/*
 circular payload memory between the splitter and the joiner
 words are written in arrival order and a packet is read back from a pointer on rd_req
*/
`timescale 1ns/1ps
`include "split_join_macros.svh"

`default_nettype none

module axi4s_pkt_buffer
   import axi4s_pkg::*;
   import buffer_pkg::*;
(
   input  logic     aclk,
   input  logic     reset,
   input  tdata_t   buf_tdata,
   input  tkeep_t   buf_tkeep,
   input  logic     buf_tlast,
   input  logic     buf_tvalid,
   output logic     buf_tready,
   output buf_ptr_t buf_wr_ptr,
   input  logic     rd_req,
   input  buf_ptr_t rd_ptr,
   output tdata_t   rd_tdata,
   output tkeep_t   rd_tkeep,
   output logic     rd_tlast,
   output logic     rd_tvalid,
   input  logic     rd_tready
);

   localparam int DEPTH = 1 << `BUF_ADDR_WID;

   typedef enum logic [1:0] {IDLE, FETCH, STREAM} rd_state_t;

   rd_state_t              rd_state;
   tdata_t                 mem_tdata [DEPTH];
   tkeep_t                 mem_tkeep [DEPTH];
   logic                   mem_tlast [DEPTH];
   logic [`BUF_ADDR_WID:0] wr_cnt;
   logic [`BUF_ADDR_WID:0] rel_cnt;
   logic [`BUF_ADDR_WID:0] used;
   buf_ptr_t               rd_addr;
   logic                   wr_fire;
   logic                   rd_fire;
   logic                   has_next;
   logic                   load;

   // the counters carry one extra bit so a full memory differs from an empty one
   assign used       = wr_cnt - rel_cnt;
   assign buf_tready = !used[`BUF_ADDR_WID];
   assign buf_wr_ptr = wr_cnt[`BUF_ADDR_WID-1:0];
   assign wr_fire    = buf_tvalid && buf_tready;
   assign rd_fire    = rd_tvalid && rd_tready;

   // packets are read in the order they were written, so the read cursor sits
   // right behind the release point and any unreleased word beyond the one in
   // the output register has already been written
   assign has_next = used > {{`BUF_ADDR_WID{1'b0}}, rd_tvalid};

   always_comb begin
      case (rd_state)
         FETCH:   load = has_next;
         STREAM:  load = has_next && (!rd_tvalid || (rd_tready && !rd_tlast));
         default: load = 1'b0;
      endcase
   end

   // ------------------------------
   // memory and read register
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (wr_fire) begin
         mem_tdata[buf_wr_ptr] <= buf_tdata;
         mem_tkeep[buf_wr_ptr] <= buf_tkeep;
         mem_tlast[buf_wr_ptr] <= buf_tlast;
      end
      if (load) begin
         rd_tdata <= mem_tdata[rd_addr];
         rd_tkeep <= mem_tkeep[rd_addr];
         rd_tlast <= mem_tlast[rd_addr];
      end
   end

   // ------------------------------
   // pointers and read FSM
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (reset) begin
         wr_cnt    <= '0;
         rel_cnt   <= '0;
         rd_addr   <= '0;
         rd_tvalid <= 1'b0;
         rd_state  <= IDLE;
      end else begin
         if (wr_fire) wr_cnt <= wr_cnt + 1'b1;
         // space comes back only once the reader has taken the word
         if (rd_fire) begin
            rel_cnt   <= rel_cnt + 1'b1;
            rd_tvalid <= 1'b0;
         end
         if (load) begin
            rd_tvalid <= 1'b1;
            rd_addr   <= rd_addr + 1'b1;
         end
         case (rd_state)
            IDLE: begin
               if (rd_req) begin
                  rd_addr  <= rd_ptr;
                  rd_state <= FETCH;
               end
            end
            FETCH: begin
               if (load) rd_state <= STREAM;
            end
            STREAM: begin
               if (rd_fire && rd_tlast) rd_state <= IDLE;
            end
            default: rd_state <= IDLE;
         endcase
      end
   end

   // a fill count past the memory size means a write landed on a word the
   // read side still owns or a word was released twice
   a_no_overflow: assert property (@(posedge aclk) disable iff (reset)
      used <= DEPTH);

   // the joiner only asks for the next packet once this one has been streamed out
   a_req_idle: assert property (@(posedge aclk) disable iff (reset)
      rd_req |-> rd_state == IDLE);

endmodule

`default_nettype wire

/* rtl/axi4s_join.sv */
/*
 joiner that rebuilds whole packets after header processing
 each processed header is forwarded first and its payload is then fetched from the buffer
*/
`timescale 1ns/1ps

`default_nettype none

module axi4s_join
   import axi4s_pkg::*;
   import buffer_pkg::*;
(
   input  logic     aclk,
   input  logic     reset,
   input  tdata_t   hdr_in_tdata,
   input  tkeep_t   hdr_in_tkeep,
   input  logic     hdr_in_tlast,
   input  logic     hdr_in_tvalid,
   output logic     hdr_in_tready,
   input  hdr_ctx_t hdr_in_tuser,
   input  tdata_t   rd_tdata,
   input  tkeep_t   rd_tkeep,
   input  logic     rd_tlast,
   input  logic     rd_tvalid,
   output logic     rd_tready,
   output logic     rd_req,
   output buf_ptr_t rd_ptr,
   output tdata_t   out_tdata,
   output tkeep_t   out_tkeep,
   output logic     out_tlast,
   output logic     out_tvalid,
   input  logic     out_tready
);

   typedef enum logic [1:0] {HDR, REQ, PLD} state_t;

   state_t   state;
   buf_ptr_t pld_ptr;
   logic     out_free;
   logic     hdr_fire;
   logic     rd_fire;

   // both inputs share the single output stage, so a stalled out holds them both
   assign out_free      = !out_tvalid || out_tready;
   assign hdr_in_tready = (state == HDR) && out_free;
   assign rd_tready     = (state == PLD) && out_free;
   assign hdr_fire      = hdr_in_tvalid && hdr_in_tready;
   assign rd_fire       = rd_tvalid && rd_tready;

   // REQ lasts a single cycle, which makes the read request a one cycle pulse
   assign rd_req = (state == REQ);
   assign rd_ptr = pld_ptr;

   always_ff @(posedge aclk) begin
      if (reset) begin
         state      <= HDR;
         out_tvalid <= 1'b0;
      end else begin
         if (out_tready) out_tvalid <= 1'b0;
         if (hdr_fire || rd_fire) out_tvalid <= 1'b1;
         case (state)
            HDR: begin
               // a header with no payload already closed its packet
               if (hdr_fire && hdr_in_tlast && hdr_in_tuser.pld_present) state <= REQ;
            end
            REQ: state <= PLD;
            PLD: begin
               if (rd_fire && rd_tlast) state <= HDR;
            end
            default: state <= HDR;
         endcase
      end
   end

   // ------------------------------
   // output word and payload pointer
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (hdr_fire) begin
         out_tdata <= hdr_in_tdata;
         out_tkeep <= hdr_in_tkeep;
         // the header tlast only ends the packet when nothing was buffered
         out_tlast <= hdr_in_tlast && !hdr_in_tuser.pld_present;
      end
      if (rd_fire) begin
         out_tdata <= rd_tdata;
         out_tkeep <= rd_tkeep;
         out_tlast <= rd_tlast;
      end
      // the context is echoed on every word but only read with the header tlast
      if (hdr_fire && hdr_in_tlast) pld_ptr <= hdr_in_tuser.pld_ptr;
   end

   // the buffer only offers payload after a request and stops at the stored tlast
   a_rd_in_pld: assert property (@(posedge aclk) disable iff (reset)
      rd_tvalid |-> state == PLD);

endmodule

`default_nettype wire

/* rtl/axi4s_split_join.sv */
/*
 in-line header processing subsystem top level
 headers leave on hdr_out for outside processing and come back on hdr_in,
 while payloads wait in the packet buffer until they are rejoined on out
*/
`timescale 1ns/1ps
`include "split_join_macros.svh"

`default_nettype none

module axi4s_split_join
   import axi4s_pkg::*;
   import buffer_pkg::*;
(
   input  logic                    aclk,
   input  logic                    reset,
   input  tdata_t                  in_tdata,
   input  tkeep_t                  in_tkeep,
   input  logic                    in_tlast,
   input  logic                    in_tvalid,
   output logic                    in_tready,
   output tdata_t                  hdr_out_tdata,
   output tkeep_t                  hdr_out_tkeep,
   output logic                    hdr_out_tlast,
   output logic                    hdr_out_tvalid,
   input  logic                    hdr_out_tready,
   output hdr_ctx_t                hdr_out_tuser,
   input  tdata_t                  hdr_in_tdata,
   input  tkeep_t                  hdr_in_tkeep,
   input  logic                    hdr_in_tlast,
   input  logic                    hdr_in_tvalid,
   output logic                    hdr_in_tready,
   input  hdr_ctx_t                hdr_in_tuser,
   output tdata_t                  out_tdata,
   output tkeep_t                  out_tkeep,
   output logic                    out_tlast,
   output logic                    out_tvalid,
   input  logic                    out_tready,
   input  logic [`HDR_CNT_WID-1:0] hdr_words
);

   // ------------------------------
   // splitter to buffer payload stream
   // ------------------------------
   tdata_t   buf_tdata;
   tkeep_t   buf_tkeep;
   logic     buf_tlast;
   logic     buf_tvalid;
   logic     buf_tready;
   buf_ptr_t buf_wr_ptr;

   // ------------------------------
   // joiner read link into the buffer
   // ------------------------------
   logic     rd_req;
   buf_ptr_t rd_ptr;
   tdata_t   rd_tdata;
   tkeep_t   rd_tkeep;
   logic     rd_tlast;
   logic     rd_tvalid;
   logic     rd_tready;

   // every port name matches the wire of the same name at this level
   axi4s_split split_i (.*);

   axi4s_pkt_buffer buffer_i (.*);

   axi4s_join join_i (.*);

endmodule

`default_nettype wire

/* dv/tb_axi4s_split_join.sv */
/*
 testbench for the in-line header split/join subsystem
 plays packet source, outside header processor and output checker at once,
 with one packet per row of the stimulus table and random ready and valid gaps
*/
`timescale 1ns/1ps
`include "split_join_macros.svh"

`default_nettype none

module tb_axi4s_split_join
   import axi4s_pkg::*;
   import buffer_pkg::*;
();

   localparam int NUM_TESTS       = 10;
   localparam int VALID_GAP_PCT   = 20;
   localparam int WATCHDOG_CYCLES = 16 + NUM_TESTS * 200;

   logic                    aclk;
   logic                    reset;
   tdata_t                  in_tdata;
   tkeep_t                  in_tkeep;
   logic                    in_tlast;
   logic                    in_tvalid;
   logic                    in_tready;
   tdata_t                  hdr_out_tdata;
   tkeep_t                  hdr_out_tkeep;
   logic                    hdr_out_tlast;
   logic                    hdr_out_tvalid;
   logic                    hdr_out_tready;
   hdr_ctx_t                hdr_out_tuser;
   tdata_t                  hdr_in_tdata;
   tkeep_t                  hdr_in_tkeep;
   logic                    hdr_in_tlast;
   logic                    hdr_in_tvalid;
   logic                    hdr_in_tready;
   hdr_ctx_t                hdr_in_tuser;
   tdata_t                  out_tdata;
   tkeep_t                  out_tkeep;
   logic                    out_tlast;
   logic                    out_tvalid;
   logic                    out_tready;
   logic [`HDR_CNT_WID-1:0] hdr_words;

   // ------------------------------
   // stimulus table
   // ------------------------------
   // rows 1 to 3 and 6 end inside their header, so they leave as the header alone
   int     tbl_len      [NUM_TESTS] = '{4, 1, 3, 2, 10, 20, 6, 16, 9, 12};
   int     tbl_hdr      [NUM_TESTS] = '{2, 1, 3, 5, 1, 4, 15, 2, 3, 8};
   tkeep_t tbl_keep     [NUM_TESTS] = '{8'hFF, 8'h0F, 8'h07, 8'h01, 8'h3F,
                                        8'hFF, 8'h7F, 8'h03, 8'h1F, 8'hFF};
   int     tbl_out_duty [NUM_TESTS] = '{100, 100, 100, 100, 50, 30, 70, 40, 60, 80};
   int     tbl_hdr_duty [NUM_TESTS] = '{100, 100, 100, 100, 60, 40, 20, 50, 90, 30};

   // input words of all packets back to back, and the packets expected on out
   tdata_t in_data  [$];
   tkeep_t in_keep  [$];
   logic   in_last  [$];
   tdata_t exp_data [$];
   tkeep_t exp_keep [$];
   logic   exp_last [$];
   int     pkt_base [NUM_TESTS];
   int     err_cnt;
   int     pass_cnt;

   axi4s_split_join dut_i (.*);

   initial begin
      aclk = 1'b0;
      forever #10 aclk = ~aclk;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   // inputs change 2 ns after the edge and are judged at the falling edge
   task automatic next_cycle();
      @(posedge aclk);
      #2;
   endtask

   function automatic logic chance(input int pct);
      return int'($urandom % 100) < pct;
   endfunction

   task automatic compare_data(input string name, input tdata_t got, input tdata_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic compare_keep(input string name, input tkeep_t got, input tkeep_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // payload bytes count up across all packets so every word is unique
   task automatic build_packets();
      logic [7:0] b;
      tdata_t     w;
      tkeep_t     k;
      int         t;
      int         i;
      int         j;
      b = 8'h00;
      for (t = 0; t < NUM_TESTS; t++) begin
         pkt_base[t] = in_data.size();
         for (i = 0; i < tbl_len[t]; i++) begin
            for (j = 0; j < `DATA_BYTE_WID; j++) begin
               w[j*8 +: 8] = b;
               b = b + 8'd1;
            end
            k = (i == tbl_len[t] - 1) ? tbl_keep[t] : '1;
            in_data.push_back(w);
            in_keep.push_back(k);
            in_last.push_back(i == tbl_len[t] - 1);
            // only the very first header byte is changed by the processor
            if (i == 0) w[7:0] = w[7:0] ^ 8'hA5;
            exp_data.push_back(w);
            exp_keep.push_back(k);
            exp_last.push_back(i == tbl_len[t] - 1);
         end
      end
   endtask

   // ------------------------------
   // packet source
   // ------------------------------
   task automatic send_packets();
      int   t;
      int   i;
      int   idx;
      logic fired;
      for (t = 0; t < NUM_TESTS; t++) begin
         hdr_words = tbl_hdr[t][`HDR_CNT_WID-1:0];
         for (i = 0; i < tbl_len[t]; i++) begin
            idx = pkt_base[t] + i;
            while (chance(VALID_GAP_PCT)) next_cycle();
            in_tdata  = in_data[idx];
            in_tkeep  = in_keep[idx];
            in_tlast  = in_last[idx];
            in_tvalid = 1'b1;
            fired     = 1'b0;
            while (!fired) begin
               @(negedge aclk);
               fired = in_tready;
               next_cycle();
            end
            in_tvalid = 1'b0;
         end
      end
   endtask

   // ------------------------------
   // outside header processor
   // ------------------------------
   task automatic process_headers();
      int       t;
      int       i;
      int       nh;
      int       idx;
      logic     fired;
      tdata_t   cap_data;
      tkeep_t   cap_keep;
      logic     cap_last;
      hdr_ctx_t cap_user;
      for (t = 0; t < NUM_TESTS; t++) begin
         // a packet shorter than its header is all header
         nh = (tbl_hdr[t] < tbl_len[t]) ? tbl_hdr[t] : tbl_len[t];
         for (i = 0; i < nh; i++) begin
            idx   = pkt_base[t] + i;
            fired = 1'b0;
            while (!fired) begin
               hdr_out_tready = chance(tbl_hdr_duty[t]);
               @(negedge aclk);
               fired    = hdr_out_tvalid && hdr_out_tready;
               cap_data = hdr_out_tdata;
               cap_keep = hdr_out_tkeep;
               cap_last = hdr_out_tlast;
               cap_user = hdr_out_tuser;
               next_cycle();
            end
            hdr_out_tready = 1'b0;
            compare_data("hdr_out_tdata", cap_data, in_data[idx]);
            compare_keep("hdr_out_tkeep", cap_keep, in_keep[idx]);
            compare_flag("hdr_out_tlast", cap_last, i == nh - 1);
            if (i == nh - 1) begin
               compare_flag("hdr_out_tuser.pld_present", cap_user.pld_present,
                            tbl_len[t] > tbl_hdr[t]);
            end
            repeat ($urandom % 4) next_cycle();
            // the context goes back untouched so the joiner finds the payload
            if (i == 0) cap_data[7:0] = cap_data[7:0] ^ 8'hA5;
            hdr_in_tdata  = cap_data;
            hdr_in_tkeep  = cap_keep;
            hdr_in_tlast  = cap_last;
            hdr_in_tuser  = cap_user;
            hdr_in_tvalid = 1'b1;
            fired         = 1'b0;
            while (!fired) begin
               @(negedge aclk);
               fired = hdr_in_tready;
               next_cycle();
            end
            hdr_in_tvalid = 1'b0;
         end
      end
      // any further header word would be a duplicate
      hdr_out_tready = 1'b1;
      repeat (20) begin
         @(negedge aclk);
         if (hdr_out_tvalid) begin
            $display("unexpected header word on hdr_out after the last packet at %0t", $time);
            err_cnt++;
         end
         next_cycle();
      end
   endtask

   // ------------------------------
   // output checker
   // ------------------------------
   task automatic check_output();
      int     t;
      int     i;
      int     idx;
      int     err_start;
      logic   fired;
      tdata_t cap_data;
      tkeep_t cap_keep;
      logic   cap_last;
      for (t = 0; t < NUM_TESTS; t++) begin
         err_start = err_cnt;
         for (i = 0; i < tbl_len[t]; i++) begin
            idx   = pkt_base[t] + i;
            fired = 1'b0;
            while (!fired) begin
               out_tready = chance(tbl_out_duty[t]);
               @(negedge aclk);
               fired    = out_tvalid && out_tready;
               cap_data = out_tdata;
               cap_keep = out_tkeep;
               cap_last = out_tlast;
               next_cycle();
            end
            compare_data("out_tdata", cap_data, exp_data[idx]);
            compare_keep("out_tkeep", cap_keep, exp_keep[idx]);
            compare_flag("out_tlast", cap_last, exp_last[idx]);
         end
         if (err_cnt == err_start) pass_cnt++;
         $display("test %0d: %0d words, hdr_words %0d, %0d mismatches",
                  t, tbl_len[t], tbl_hdr[t], err_cnt - err_start);
      end
      out_tready = 1'b1;
      repeat (20) begin
         @(negedge aclk);
         if (out_tvalid) begin
            $display("unexpected word on out after the last packet at %0t", $time);
            err_cnt++;
         end
         next_cycle();
      end
   endtask

   // ------------------------------
   // run control
   // ------------------------------
   initial begin
      void'($urandom(69045));
      err_cnt        = 0;
      pass_cnt       = 0;
      reset          = 1'b1;
      in_tdata       = '0;
      in_tkeep       = '0;
      in_tlast       = 1'b0;
      in_tvalid      = 1'b0;
      hdr_out_tready = 1'b0;
      hdr_in_tdata   = '0;
      hdr_in_tkeep   = '0;
      hdr_in_tlast   = 1'b0;
      hdr_in_tvalid  = 1'b0;
      hdr_in_tuser   = '0;
      out_tready     = 1'b0;
      hdr_words      = '0;
      build_packets();
      repeat (16) @(posedge aclk);
      #2;
      reset = 1'b0;
      fork
         send_packets();
         process_headers();
         check_output();
      join
      $display("%0d of %0d tests clean, %0d errors", pass_cnt, NUM_TESTS, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // each row gets a generous budget of cycles on top of the reset time
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge aclk);
      $display("timeout after %0d cycles, the packets did not all come out", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/axi4s_pkg.sv
rtl/buffer_pkg.sv
rtl/axi4s_split.sv
rtl/axi4s_pkt_buffer.sv
rtl/axi4s_join.sv
rtl/axi4s_split_join.sv
dv/tb_axi4s_split_join.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the split/join testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

top=tb_axi4s_split_join
log=sim.log

verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
   --top-module "$top" -Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Errors found" "$log"; then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"
exit 0
